// ==== design/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    // Datapath and fetch width
    localparam int xlen = 32;
    localparam int ways = 2;
    localparam int inst_bytes = 4;
    localparam logic [xlen-1:0] fetch_stride = ways * inst_bytes;
    localparam logic [xlen-1:0] reset_pc = '0;

    // Predictor tables, indexed by pc[bp_index_bits+1:2]
    localparam int bp_entries = 128;
    localparam int bp_index_bits = $clog2(bp_entries);

    // Fetch queue
    localparam int fq_depth = 4;
    localparam int fq_ptr_bits = $clog2(fq_depth);
    localparam int fq_count_bits = $clog2(fq_depth + 1);

    // Control-transfer opcodes
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal = 7'b1101111;

    typedef logic [bp_index_bits-1:0] bp_index_t;
    typedef logic [fq_ptr_bits-1:0] fq_ptr_t;
    typedef logic [fq_count_bits-1:0] fq_count_t;

    // One fetched bundle as it travels toward decode
    typedef struct packed {
        logic [xlen-1:0]           pc;
        logic [ways-1:0][xlen-1:0] insts;
        logic [ways-1:0]           lane_valid;
        logic [ways-1:0]           predicted;
        logic [xlen-1:0]           pred_next_pc;
    } fetch_bundle_t;

    // Resolved branch from commit
    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
    } bp_update_t;

endpackage

`default_nettype wire

// ==== design/branch_pred.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_pred (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic [frontend_pkg::xlen-1:0]                  pc,
    input  logic [frontend_pkg::ways-1:0]                  is_branch,
    input  frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] update,
    output logic [frontend_pkg::xlen-1:0]                  next_pc,
    output logic [frontend_pkg::ways-1:0]                  predictions
);

    // Branch target buffer and two-bit counters
    logic [frontend_pkg::xlen-1:0] btb [frontend_pkg::bp_entries];
    logic [frontend_pkg::bp_entries-1:0] btb_valid;
    logic [1:0] pht [frontend_pkg::bp_entries];

    // Table contents after this cycle's commit updates
    logic [frontend_pkg::xlen-1:0] btb_next [frontend_pkg::bp_entries];
    logic [frontend_pkg::bp_entries-1:0] btb_valid_next;
    logic [1:0] pht_next [frontend_pkg::bp_entries];

    frontend_pkg::bp_index_t base_index;

    assign base_index = pc[frontend_pkg::bp_index_bits+1:2];

    // Lookup, first qualifying lane wins
    always_comb begin
        frontend_pkg::bp_index_t idx;
        logic found;
        next_pc = pc + frontend_pkg::fetch_stride;
        predictions = '0;
        found = 1'b0;
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            // Lane index wraps around the table
            idx = base_index + frontend_pkg::bp_index_t'(i);
            if (!found && is_branch[i] && pht[idx][1] && btb_valid[idx]) begin
                next_pc = btb[idx];
                predictions[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    // Updates applied in lane order so a later lane sees an earlier one
    always_comb begin
        frontend_pkg::bp_index_t idx;
        btb_next = btb;
        btb_valid_next = btb_valid;
        pht_next = pht;
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            idx = update[i].pc[frontend_pkg::bp_index_bits+1:2];
            if (update[i].valid) begin
                if (update[i].taken) begin
                    btb_next[idx] = update[i].target;
                    btb_valid_next[idx] = 1'b1;
                    if (pht_next[idx] != 2'b11) begin
                        pht_next[idx] = pht_next[idx] + 2'd1;
                    end
                end else if (pht_next[idx] != 2'b00) begin
                    pht_next[idx] = pht_next[idx] - 2'd1;
                end
            end
        end
    end

    // Targets are only read when their valid bit is set
    always_ff @(posedge clock) begin
        btb <= btb_next;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
            // Start weakly not taken
            for (int e = 0; e < frontend_pkg::bp_entries; e++) begin
                pht[e] <= 2'b01;
            end
        end else begin
            btb_valid <= btb_valid_next;
            pht <= pht_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/predecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecode (
    input  logic [frontend_pkg::ways-1:0][frontend_pkg::xlen-1:0] insts,
    output logic [frontend_pkg::ways-1:0]                         is_branch
);

    // Opcode field of each lane
    logic [6:0] opcode [frontend_pkg::ways];

    always_comb begin
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            opcode[i] = insts[i][6:0];
        end
    end

    // Conditional branches and direct jumps both go to the predictor
    always_comb begin
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            is_branch[i] = (opcode[i] == frontend_pkg::opcode_branch)
                        || (opcode[i] == frontend_pkg::opcode_jal);
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_pc.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_pc (
    input  logic                                                  clock,
    input  logic                                                  reset,
    input  logic                                                  redirect_valid,
    input  logic [frontend_pkg::xlen-1:0]                         redirect_pc,
    input  logic [frontend_pkg::ways-1:0][frontend_pkg::xlen-1:0] imem_data,
    input  logic [frontend_pkg::xlen-1:0]                         next_pc,
    input  logic [frontend_pkg::ways-1:0]                         predictions,
    input  logic                                                  push_ready,
    output logic [frontend_pkg::xlen-1:0]                         pc,
    output logic                                                  push_valid,
    output frontend_pkg::fetch_bundle_t                           push_bundle
);

    logic push_fire;
    logic [frontend_pkg::ways-1:0] lane_valid;

    // A redirecting cycle fetches nothing useful
    assign push_valid = !redirect_valid;
    assign push_fire = push_valid && push_ready;

    // PC holds when the queue is full, so the same bundle is fetched again
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= frontend_pkg::reset_pc;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (push_fire) begin
            pc <= next_pc;
        end
    end

    // Lanes past the first predicted-taken lane are dropped
    always_comb begin
        logic taken_seen;
        taken_seen = 1'b0;
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            lane_valid[i] = !taken_seen;
            taken_seen = taken_seen | predictions[i];
        end
    end

    always_comb begin
        push_bundle.pc = pc;
        push_bundle.insts = imem_data;
        push_bundle.lane_valid = lane_valid;
        push_bundle.predicted = predictions;
        push_bundle.pred_next_pc = next_pc;
    end

endmodule

`default_nettype wire

// ==== design/fetch_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_queue (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        push_valid,
    input  frontend_pkg::fetch_bundle_t push_bundle,
    output logic                        push_ready,
    output logic                        out_valid,
    output frontend_pkg::fetch_bundle_t out_bundle,
    input  logic                        out_ready
);

    frontend_pkg::fetch_bundle_t entries [frontend_pkg::fq_depth];

    frontend_pkg::fq_ptr_t wr_ptr;
    frontend_pkg::fq_ptr_t rd_ptr;
    frontend_pkg::fq_count_t count;

    logic push_fire;
    logic pop_fire;

    // Circular pointer advance, also for depths that are not a power of two
    function automatic frontend_pkg::fq_ptr_t ptr_inc(input frontend_pkg::fq_ptr_t ptr);
        if (ptr == frontend_pkg::fq_ptr_t'(frontend_pkg::fq_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready = (count != frontend_pkg::fq_count_t'(frontend_pkg::fq_depth));
    assign out_valid = (count != '0);
    assign out_bundle = entries[rd_ptr];

    // Flush wins over both sides
    assign push_fire = push_valid && push_ready && !flush;
    assign pop_fire = out_valid && out_ready && !flush;

    always_ff @(posedge clock) begin
        if (push_fire) begin
            entries[wr_ptr] <= push_bundle;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop leave the count alone
            case ({push_fire, pop_fire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input  logic                                                  clock,
    input  logic                                                  reset,
    output logic [frontend_pkg::xlen-1:0]                         imem_addr,
    input  logic [frontend_pkg::ways-1:0][frontend_pkg::xlen-1:0] imem_data,
    input  frontend_pkg::bp_update_t [frontend_pkg::ways-1:0]     commit_update,
    input  logic                                                  redirect_valid,
    input  logic [frontend_pkg::xlen-1:0]                         redirect_pc,
    output logic                                                  out_valid,
    output frontend_pkg::fetch_bundle_t                           out_bundle,
    input  logic                                                  out_ready
);

    logic [frontend_pkg::ways-1:0] is_branch;
    logic [frontend_pkg::ways-1:0] predictions;
    logic [frontend_pkg::xlen-1:0] next_pc;
    logic                          push_valid;
    logic                          push_ready;
    frontend_pkg::fetch_bundle_t   push_bundle;

    // Fetch PC addresses both the memory and the predictor
    fetch_pc i_fetch_pc (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_data      (imem_data),
        .next_pc        (next_pc),
        .predictions    (predictions),
        .push_ready     (push_ready),
        .pc             (imem_addr),
        .push_valid     (push_valid),
        .push_bundle    (push_bundle)
    );

    predecode i_predecode (
        .insts     (imem_data),
        .is_branch (is_branch)
    );

    branch_pred i_branch_pred (
        .clock       (clock),
        .reset       (reset),
        .pc          (imem_addr),
        .is_branch   (is_branch),
        .update      (commit_update),
        .next_pc     (next_pc),
        .predictions (predictions)
    );

    // Redirect drops everything still queued
    fetch_queue i_fetch_queue (
        .clock       (clock),
        .reset       (reset),
        .flush       (redirect_valid),
        .push_valid  (push_valid),
        .push_bundle (push_bundle),
        .push_ready  (push_ready),
        .out_valid   (out_valid),
        .out_bundle  (out_bundle),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

// ==== verification/fetch_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_props (
    input logic                        clock,
    input logic                        reset,
    input logic                        flush,
    input logic                        push_valid,
    input logic                        out_valid,
    input logic                        out_ready,
    input frontend_pkg::fetch_bundle_t out_bundle,
    input frontend_pkg::fq_count_t     count,
    input frontend_pkg::fq_ptr_t       wr_ptr
);

    // A waiting bundle stays put until decode takes it
    bundle_stable: assert property (
        @(posedge clock) disable iff (reset)
        (out_valid && !out_ready && !flush) |=> $stable(out_bundle)
    ) else $error("out_bundle changed while out_valid was high and out_ready low");

    // Full queue keeps its write pointer even when offered a bundle
    no_push_when_full: assert property (
        @(posedge clock) disable iff (reset)
        (push_valid && !flush && (count == frontend_pkg::fq_count_t'(frontend_pkg::fq_depth)))
            |=> $stable(wr_ptr)
    ) else $error("fetch queue accepted a push while full");

    empty_after_flush: assert property (
        @(posedge clock) disable iff (reset)
        flush |=> !out_valid
    ) else $error("out_valid high in the cycle after a flush");

endmodule

bind fetch_queue fetch_props i_fetch_props (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .push_valid (push_valid),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bundle (out_bundle),
    .count      (count),
    .wr_ptr     (wr_ptr)
);

`default_nettype wire

// ==== verification/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

    logic                                                  clock;
    logic                                                  reset;
    logic [frontend_pkg::xlen-1:0]                         imem_addr;
    logic [frontend_pkg::ways-1:0][frontend_pkg::xlen-1:0] imem_data;
    frontend_pkg::bp_update_t [frontend_pkg::ways-1:0]     commit_update;
    logic                                                  redirect_valid;
    logic [frontend_pkg::xlen-1:0]                         redirect_pc;
    logic                                                  out_valid;
    frontend_pkg::fetch_bundle_t                           out_bundle;
    logic                                                  out_ready;

    // Predictor model tables
    logic [31:0] model_btb [frontend_pkg::bp_entries];
    logic        model_btb_valid [frontend_pkg::bp_entries];
    logic [1:0]  model_counter [frontend_pkg::bp_entries];

    logic [31:0] lfsr_state;
    logic [31:0] expected_pc;
    logic [31:0] last_pc;
    logic        seen_valid;
    logic        redirect_pending;
    logic [31:0] redirect_target;
    int          errors;
    int          checks;
    int          accepted;
    bit          timed_out;

    fetch_top i_fetch_top (
        .clock          (clock),
        .reset          (reset),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .commit_update  (commit_update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out_bundle     (out_bundle),
        .out_ready      (out_ready)
    );

    always #50 clock = ~clock;

    // Instruction memory contents hashed from the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e3779b1;
        h = h ^ (h >> 13) ^ (addr << 7);
        case (h[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: return {h[31:7], frontend_pkg::opcode_branch};
            4'd4: return {h[31:7], frontend_pkg::opcode_jal};
            default: return {h[31:7], 7'b0010011};
        endcase
    endfunction

    assign imem_data[0] = mem_word(imem_addr);
    assign imem_data[1] = mem_word(imem_addr + 32'd4);

    function automatic logic is_control(input logic [31:0] inst);
        return (inst[6:0] == frontend_pkg::opcode_branch)
            || (inst[6:0] == frontend_pkg::opcode_jal);
    endfunction

    function automatic frontend_pkg::bp_index_t table_index(input logic [31:0] addr);
        return addr[frontend_pkg::bp_index_bits+1:2];
    endfunction

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_equal(input string what, input logic [255:0] actual,
                               input logic [255:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic reset_model();
        for (int e = 0; e < frontend_pkg::bp_entries; e++) begin
            model_btb[e] = '0;
            model_btb_valid[e] = 1'b0;
            model_counter[e] = 2'd1;
        end
    endtask

    // Lane order lets lane 1 have the last word on a shared entry
    task automatic apply_model(input frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] upd);
        frontend_pkg::bp_index_t idx;
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            idx = table_index(upd[i].pc);
            if (upd[i].valid && upd[i].taken) begin
                model_btb[idx] = upd[i].target;
                model_btb_valid[idx] = 1'b1;
                if (model_counter[idx] < 2'd3) begin
                    model_counter[idx] = model_counter[idx] + 2'd1;
                end
            end else if (upd[i].valid && model_counter[idx] > 2'd0) begin
                model_counter[idx] = model_counter[idx] - 2'd1;
            end
        end
    endtask

    function automatic frontend_pkg::fetch_bundle_t expect_bundle(input logic [31:0] pc);
        frontend_pkg::fetch_bundle_t b;
        frontend_pkg::bp_index_t idx;
        logic found;
        b = '0;
        b.pc = pc;
        b.pred_next_pc = pc + 32'd8;
        found = 1'b0;
        for (int i = 0; i < frontend_pkg::ways; i++) begin
            b.insts[i] = mem_word(pc + 32'(4 * i));
            idx = table_index(pc) + frontend_pkg::bp_index_t'(i);
            b.lane_valid[i] = !found;
            if (!found && is_control(b.insts[i]) && model_counter[idx][1]
                    && model_btb_valid[idx]) begin
                b.predicted[i] = 1'b1;
                b.pred_next_pc = model_btb[idx];
                found = 1'b1;
            end
        end
        return b;
    endfunction

    function automatic frontend_pkg::bp_update_t make_update(input logic taken,
            input logic [31:0] pc, input logic [31:0] target);
        frontend_pkg::bp_update_t u;
        u.valid = 1'b1;
        u.taken = taken;
        u.pc = pc;
        u.target = target;
        return u;
    endfunction

    // First control word at or after start
    function automatic logic [31:0] find_control_addr(input logic [31:0] start);
        for (int k = 0; k < 1024; k++) begin
            if (is_control(mem_word(start + 32'(4 * k)))) begin
                return start + 32'(4 * k);
            end
        end
        return start;
    endfunction

    // Accepted bundle against the stream and the model
    task automatic check_bundle(input frontend_pkg::fetch_bundle_t b);
        frontend_pkg::fetch_bundle_t exp;
        exp = expect_bundle(expected_pc);
        check_equal("bundle pc", b.pc, expected_pc);
        check_equal("bundle insts", b.insts, exp.insts);
        check_equal("bundle lane_valid", b.lane_valid, exp.lane_valid);
        check_equal("bundle predicted", b.predicted, exp.predicted);
        check_equal("bundle pred_next_pc", b.pred_next_pc, exp.pred_next_pc);
        expected_pc = exp.pred_next_pc;
        last_pc = b.pc;
        accepted++;
    endtask

    // Drive one cycle on the falling edge while outputs are stable
    task automatic step(input logic rdr, input logic [31:0] rpc, input logic ready,
                        input frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] upd);
        @(negedge clock);
        // Fetch address picks up the redirect target at the edge just passed
        if (redirect_pending) begin
            check_equal("imem_addr after redirect", imem_addr, redirect_target);
        end
        redirect_pending = rdr;
        redirect_target = rpc;
        redirect_valid = rdr;
        redirect_pc = rpc;
        out_ready = ready;
        commit_update = upd;
        seen_valid = out_valid;
        if (out_valid && ready && !rdr) begin
            check_bundle(out_bundle);
        end
        if (rdr) begin
            expected_pc = rpc;
        end
        apply_model(upd);
    endtask

    task automatic step_until_valid(input logic ready, input int limit, output int cycles);
        cycles = 0;
        seen_valid = 1'b0;
        while (!seen_valid && !timed_out) begin
            step(1'b0, '0, ready, '0);
            cycles++;
            if (!seen_valid && cycles >= limit) begin
                timed_out = 1'b1;
                $display("Timeout: out_valid did not rise within %0d cycles", limit);
            end
        end
    endtask

    task automatic redirect_and_peek(input logic [31:0] addr,
            input frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] upd);
        int n;
        step(1'b1, addr, 1'b0, upd);
        step_until_valid(1'b0, 8, n);
        check_equal("bundle pc after redirect", out_bundle.pc, addr);
    endtask

    task automatic test_first_bundle();
        int n;
        step_until_valid(1'b0, 10, n);
        check_equal("first pc", out_bundle.pc, frontend_pkg::reset_pc);
        check_equal("first pred_next_pc", out_bundle.pred_next_pc, 32'd8);
        check_equal("first predicted", out_bundle.predicted, 2'b00);
        step(1'b0, '0, 1'b1, '0);
        // Redirect to first bundle takes two cycles
        step(1'b1, 32'h40, 1'b1, '0);
        step_until_valid(1'b1, 8, n);
        check_equal("redirect latency", n, 2);
    endtask

    task automatic test_taken_training();
        frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] upd;
        logic [31:0] a;
        int n;
        a = find_control_addr(32'h200);
        upd = '0;
        upd[0] = make_update(1'b1, a, 32'h300);
        redirect_and_peek(a, upd);
        check_equal("trained predicted", out_bundle.predicted, 2'b01);
        check_equal("trained lane_valid", out_bundle.lane_valid, 2'b01);
        check_equal("trained target", out_bundle.pred_next_pc, 32'h300);
        step(1'b0, '0, 1'b1, '0);
        step_until_valid(1'b1, 8, n);
        check_equal("pc after taken", last_pc, 32'h300);
    endtask

    task automatic test_saturation();
        frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] upd;
        logic [31:0] a;
        a = find_control_addr(32'h280);
        upd = '0;
        upd[0] = make_update(1'b1, a, 32'h80);
        repeat (3) step(1'b1, a, 1'b1, upd);
        redirect_and_peek(a, upd);
        check_equal("lane 0 saturated taken", out_bundle.predicted[0], 1'b1);
        step(1'b0, '0, 1'b1, '0);
        upd[0] = make_update(1'b0, a, 32'h80);
        repeat (3) step(1'b1, a, 1'b1, upd);
        redirect_and_peek(a, upd);
        check_equal("lane 0 saturated not taken", out_bundle.predicted[0], 1'b0);
        step(1'b0, '0, 1'b1, '0);
        // Two lanes on one entry in the same cycle
        upd[0] = make_update(1'b1, a, 32'h80);
        upd[1] = make_update(1'b1, a, 32'hc0);
        redirect_and_peek(a, upd);
        check_equal("lane 1 target wins", out_bundle.pred_next_pc, 32'hc0);
        step(1'b0, '0, 1'b1, '0);
        upd[1] = make_update(1'b0, a, 32'hc0);
        redirect_and_peek(a, upd);
        check_equal("taken then not taken", out_bundle.pred_next_pc, 32'h80);
        step(1'b0, '0, 1'b1, '0);
    endtask

    task automatic test_flush();
        int n;
        step(1'b1, 32'h20, 1'b0, '0);
        repeat (6) step(1'b0, '0, 1'b0, '0);
        check_equal("queue holds bundles", seen_valid, 1'b1);
        step(1'b1, 32'h1a0, 1'b1, '0);
        step_until_valid(1'b1, 8, n);
        check_equal("first pc after flush", last_pc, 32'h1a0);
    endtask

    // Commit updates only come with a redirect
    task automatic run_random(input int cycles);
        frontend_pkg::bp_update_t [frontend_pkg::ways-1:0] upd;
        logic [31:0] r;
        logic [31:0] rpc;
        logic rdr;
        logic ready;
        for (int c = 0; c < cycles; c++) begin
            rand_bits(3, r);
            rdr = (r == 0);
            rand_bits(1, r);
            ready = r[0];
            rand_bits(5, r);
            rpc = 32'h100 + (r << 2);
            upd = '0;
            for (int i = 0; i < frontend_pkg::ways && rdr; i++) begin
                rand_bits(1, r);
                upd[i].valid = r[0];
                rand_bits(1, r);
                upd[i].taken = r[0];
                rand_bits(5, r);
                upd[i].pc = 32'h100 + (r << 2);
                rand_bits(5, r);
                upd[i].target = 32'h100 + (r << 2);
            end
            rand_bits(1, r);
            if (r[0]) begin
                upd[1].pc = upd[0].pc;
            end
            step(rdr, rpc, ready, upd);
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        out_ready = 1'b0;
        commit_update = '0;
        lfsr_state = 32'hd61e5513;
        expected_pc = frontend_pkg::reset_pc;
        last_pc = '0;
        seen_valid = 1'b0;
        redirect_pending = 1'b0;
        redirect_target = '0;
        errors = 0;
        checks = 0;
        accepted = 0;
        timed_out = 1'b0;
        reset_model();
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_equal("out_valid after reset", out_valid, 1'b0);
        check_equal("imem_addr after reset", imem_addr, frontend_pkg::reset_pc);
        test_first_bundle();
        if (!timed_out) test_taken_training();
        if (!timed_out) test_saturation();
        if (!timed_out) test_flush();
        if (!timed_out) run_random(800);
        check_equal("enough bundles delivered", accepted > 200, 1'b1);
        $display("Checks: %0d, errors: %0d, timeouts: %0d, bundles: %0d",
                 checks, errors, timed_out, accepted);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/frontend_pkg.sv
design/branch_pred.sv
design/predecode.sv
design/fetch_pc.sv
design/fetch_queue.sv
design/fetch_top.sv
verification/fetch_props.sv
verification/fetch_tb.sv
